// ==== src/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 64;
    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcodes of the supported subset
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal = 7'b1101111;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b, // lui puts the immediate straight through
        alu_link    // pc plus 4, the return address of jal
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_jal
    } branch_t;

    typedef struct packed {
        alu_op_t alu_op;
        branch_t branch;
        logic use_imm;
        logic write_rd;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t imm;
    } decoded_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        decoded_t dec;
        word_t rs1_data;
        word_t rs2_data;
    } issue_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
        logic write_rd;
        reg_addr_t rd;
        word_t data;
    } retire_t;

endpackage

// ==== src/register_file.sv ====
module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      write_enable,
    input  reg_addr_t write_addr,
    input  word_t     write_data
);

    word_t regs [31:1]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // a write in the same cycle is passed straight to the reader
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (write_enable && write_addr == rs1_addr) ? write_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (write_enable && write_addr == rs2_addr) ? write_data : regs[rs2_addr];

endmodule

// ==== src/fetch_stage.sv ====
module fetch_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   redirect,
    input  addr_t  redirect_pc,
    output addr_t  inst_addr,
    input  inst_t  inst_data,
    output fetch_t fetched
);

    addr_t pc;
    addr_t pc_next;

    assign inst_addr = pc; // the instruction memory answers in the same cycle

    // a taken branch in execute overrides sequential fetch
    assign pc_next = redirect ? redirect_pc : pc + addr_t'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // the word fetched in this cycle is on the wrong path when redirect is high
    always_ff @(posedge clk) begin
        if (reset) begin
            fetched.valid <= 1'b0;
        end else begin
            fetched.valid <= ~redirect;
            fetched.pc <= pc;
            fetched.inst <= inst_data;
        end
    end

endmodule

// ==== src/decode_stage.sv ====
module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  fetch_t    fetched,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output issue_t    issued
);

    inst_t inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    decoded_t dec;

    assign inst = fetched.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // anything not matched below falls out as a no-op with zero data
        dec.alu_op = alu_pass_b;
        dec.branch = br_none;
        dec.use_imm = 1'b1;
        dec.write_rd = 1'b0;
        dec.rd = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.imm = '0;
        case (opcode)
            opcode_op: begin
                dec.use_imm = 1'b0;
                dec.write_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = alu_add;
                    {7'b0100000, 3'b000}: dec.alu_op = alu_sub;
                    {7'b0000000, 3'b111}: dec.alu_op = alu_and;
                    {7'b0000000, 3'b110}: dec.alu_op = alu_or;
                    {7'b0000000, 3'b100}: dec.alu_op = alu_xor;
                    default: begin
                        dec.alu_op = alu_pass_b;
                        dec.use_imm = 1'b1;
                        dec.write_rd = 1'b0;
                    end
                endcase
            end
            opcode_op_imm: begin
                dec.imm = imm_i;
                dec.write_rd = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = alu_add;
                    3'b111: dec.alu_op = alu_and;
                    3'b110: dec.alu_op = alu_or;
                    3'b100: dec.alu_op = alu_xor;
                    default: begin
                        dec.imm = '0;
                        dec.write_rd = 1'b0;
                    end
                endcase
            end
            opcode_lui: begin
                dec.imm = imm_u;
                dec.write_rd = 1'b1;
            end
            opcode_branch: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000: dec.branch = br_beq;
                    3'b001: dec.branch = br_bne;
                    3'b100: dec.branch = br_blt;
                    default: dec.imm = '0;
                endcase
            end
            opcode_jal: begin
                dec.imm = imm_j;
                dec.alu_op = alu_link;
                dec.branch = br_jal;
                dec.write_rd = 1'b1;
            end
            default: ;
        endcase
    end

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    always_ff @(posedge clk) begin
        if (reset) begin
            issued.valid <= 1'b0;
        end else begin
            issued.valid <= fetched.valid & ~flush; // younger than a taken branch
            issued.pc <= fetched.pc;
            issued.dec <= dec;
            issued.rs1_data <= rs1_data;
            issued.rs2_data <= rs2_data;
        end
    end

endmodule

// ==== src/execute_stage.sv ====
module execute_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  issue_t  issued,
    output logic    redirect,
    output addr_t   redirect_pc,
    output retire_t retired
);

    logic wb_writes;
    logic fwd_rs1;
    logic fwd_rs2;
    word_t op_a;
    word_t op_rs2;
    word_t op_b;
    word_t result;
    logic taken;

    // writeback is the only stage ahead of execute that can hold a newer value
    assign wb_writes = retired.valid & retired.write_rd;
    assign fwd_rs1 = wb_writes && retired.rd == issued.dec.rs1 && issued.dec.rs1 != '0;
    assign fwd_rs2 = wb_writes && retired.rd == issued.dec.rs2 && issued.dec.rs2 != '0;

    assign op_a = fwd_rs1 ? retired.data : issued.rs1_data;
    assign op_rs2 = fwd_rs2 ? retired.data : issued.rs2_data;
    assign op_b = issued.dec.use_imm ? issued.dec.imm : op_rs2;

    always_comb begin
        case (issued.dec.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            alu_pass_b: result = op_b;
            alu_link:   result = issued.pc + addr_t'(4);
            default:    result = '0;
        endcase
    end

    // branches compare the two register operands, never the immediate
    always_comb begin
        case (issued.dec.branch)
            br_beq:  taken = (op_a == op_rs2);
            br_bne:  taken = (op_a != op_rs2);
            br_blt:  taken = ($signed(op_a) < $signed(op_rs2));
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = issued.valid & taken;
    assign redirect_pc = issued.pc + issued.dec.imm; // jal and branches are both pc relative

    always_ff @(posedge clk) begin
        if (reset) begin
            retired.valid <= 1'b0;
        end else begin
            retired.valid <= issued.valid;
            retired.pc <= issued.pc;
            retired.write_rd <= issued.dec.write_rd; // already low for branches
            retired.rd <= issued.dec.rd;
            retired.data <= result;
        end
    end

endmodule

// ==== src/core_top.sv ====
module core_top import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output addr_t   inst_addr,
    input  inst_t   inst_data,
    output retire_t retire
);

    fetch_t fetched;
    issue_t issued;
    logic redirect;
    addr_t redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    logic rf_write_enable;

    assign rf_write_enable = retire.valid & retire.write_rd;

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .fetched     (fetched)
    );

    // the same redirect squashes the word sitting in decode
    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .flush    (redirect),
        .fetched  (fetched),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .issued   (issued)
    );

    register_file u_regs (
        .clk          (clk),
        .reset        (reset),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .write_enable (rf_write_enable),
        .write_addr   (retire.rd),
        .write_data   (retire.data)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .issued      (issued),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .retired     (retire)
    );

endmodule

// ==== verification/tb_model.svh ====
`ifndef tb_model_svh
`define tb_model_svh

// architectural state of the reference model
word_t model_regs [32];
addr_t model_pc;

function automatic void model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    model_pc = reset_pc;
endfunction

// executes one instruction and returns what the core should retire for it
function automatic retire_t model_step(input inst_t inst);
    retire_t r;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_b;
    word_t imm_j;
    logic taken;
    a = model_regs[inst[19:15]];
    b = model_regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    taken = 1'b0;
    r = '0;
    r.valid = 1'b1;
    r.pc = model_pc;
    r.rd = inst[11:7];
    case (inst[6:0])
        7'b0110011: begin // register-register
            r.write_rd = 1'b1;
            case ({inst[31:25], inst[14:12]})
                10'b0000000_000: r.data = a + b;
                10'b0100000_000: r.data = a - b;
                10'b0000000_111: r.data = a & b;
                10'b0000000_110: r.data = a | b;
                10'b0000000_100: r.data = a ^ b;
                default: r.write_rd = 1'b0;
            endcase
        end
        7'b0010011: begin // register-immediate
            r.write_rd = 1'b1;
            case (inst[14:12])
                3'b000: r.data = a + imm_i;
                3'b111: r.data = a & imm_i;
                3'b110: r.data = a | imm_i;
                3'b100: r.data = a ^ imm_i;
                default: r.write_rd = 1'b0;
            endcase
        end
        7'b0110111: begin // lui
            r.write_rd = 1'b1;
            r.data = {{32{inst[31]}}, inst[31:12], 12'b0};
        end
        7'b1100011: begin
            case (inst[14:12])
                3'b000: taken = (a == b);
                3'b001: taken = (a != b);
                3'b100: taken = ($signed(a) < $signed(b));
                default: taken = 1'b0;
            endcase
        end
        7'b1101111: begin // jal links to the next word
            r.write_rd = 1'b1;
            r.data = model_pc + 64'd4;
        end
        default: ;
    endcase
    if (r.write_rd && r.rd != 5'd0) begin
        model_regs[r.rd] = r.data;
    end
    if (inst[6:0] == 7'b1101111) begin
        model_pc = model_pc + imm_j;
    end else if (taken) begin
        model_pc = model_pc + imm_b;
    end else begin
        model_pc = model_pc + 64'd4;
    end
    return r;
endfunction

`endif

// ==== verification/tb_core.sv ====
module tb_core import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int prog_words = 64;
    localparam int num_programs = 3;
    localparam int max_cycles = 2000;
    localparam addr_t last_pc = addr_t'((prog_words - 1) * 4);

    logic clk;
    logic reset;
    addr_t inst_addr;
    inst_t inst_data;
    retire_t retire;
    inst_t program_mem [prog_words];
    logic [31:0] rand_state;

    `include "tb_model.svh"

    core_top DUT (
        .clk       (clk),
        .reset     (reset),
        .inst_addr (inst_addr),
        .inst_data (inst_data),
        .retire    (retire)
    );

    // fetches past the last word wrap around and are flushed by its self-loop
    assign inst_data = program_mem[inst_addr[7:2]];

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // the low bits of the generator have short periods, so draws use the upper half
    function automatic int unsigned random_below(input int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return r[31:16] % n;
    endfunction

    function automatic inst_t random_inst(input int idx);
        logic [31:0] r;
        logic [12:0] off_b;
        logic [20:0] off_j;
        logic [6:0] f7;
        logic [2:0] f3;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        int unsigned kind;
        kind = random_below(16);
        rd = reg_addr_t'(random_below(8)); // x0..x7 keeps dependences close together
        rs1 = reg_addr_t'(random_below(8));
        rs2 = reg_addr_t'(random_below(8));
        r = next_rand();
        off_b = 13'(4 * (1 + random_below(prog_words - 1 - idx))); // always forward and inside the program
        off_j = 21'(off_b);
        f7 = 7'b0000000;
        if (kind == 0) begin
            return {r[31:7], 7'b0000011}; // load opcodes lie outside the subset
        end else if (kind <= 5) begin
            case (random_below(5))
                0: f3 = 3'b000;
                1: {f7, f3} = {7'b0100000, 3'b000};
                2: f3 = 3'b111;
                3: f3 = 3'b110;
                default: f3 = 3'b100;
            endcase
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind <= 9) begin
            case (random_below(4))
                0: f3 = 3'b000;
                1: f3 = 3'b111;
                2: f3 = 3'b110;
                default: f3 = 3'b100;
            endcase
            return {r[31:20], rs1, f3, rd, 7'b0010011};
        end else if (kind <= 11) begin
            return {r[31:12], rd, 7'b0110111};
        end else if (kind <= 14) begin
            case (random_below(3))
                0: f3 = 3'b000;
                1: f3 = 3'b001;
                default: f3 = 3'b100;
            endcase
            return {off_b[12], off_b[10:5], rs2, rs1, f3, off_b[4:1], off_b[11], 7'b1100011};
        end
        return {off_j[20], off_j[10:1], off_j[11], off_j[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string field, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, field, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic compare_retire(input retire_t expected);
        check_value("retire.pc", retire.pc, expected.pc);
        check_value("retire.write_rd", retire.write_rd, expected.write_rd);
        if (expected.write_rd) begin
            check_value("retire.rd", retire.rd, expected.rd);
            check_value("retire.data", retire.data, expected.data);
        end
    endtask

    task automatic run_program(input int prog);
        retire_t expected;
        int cycles;
        logic first;
        logic done;
        for (int idx = 0; idx < prog_words - 1; idx++) begin
            program_mem[idx] = random_inst(idx);
        end
        program_mem[prog_words - 1] = 32'h0000006f; // jal x0 to itself
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_value("retire.valid during reset", retire.valid, 1'b0);
            end
            @(posedge clk);
        end
        reset <= 1'b0;
        model_reset();
        first = 1'b1;
        done = 1'b0;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            if (retire.valid) begin
                if (first) begin
                    check_value("first retired pc", retire.pc, reset_pc);
                end
                first = 1'b0;
                expected = model_step(program_mem[model_pc[7:2]]);
                compare_retire(expected);
                done = (retire.pc == last_pc);
            end
            cycles++;
            if (!done && cycles >= max_cycles) begin
                $display("timeout: program %0d did not reach its final self-loop in %0d cycles",
                         prog, max_cycles);
                $display("TESTS FAILED");
                $fatal(1, "timeout");
            end
        end
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk = 1'b0;
        reset = 1'b1;
        rand_state = 32'hca81e86e;
        for (int p = 0; p < num_programs; p++) begin
            run_program(p);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verification
src/core_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/core_top.sv
verification/tb_core.sv
